// File: Bender.yml
package:
  name: side_ch

sources:
  - files:
      - rtl/side_ch_evt_pkg.sv
      - rtl/side_ch_reg_pkg.sv
      - rtl/side_ch_event_sel.sv
      - rtl/side_ch_counter_bank.sv
      - rtl/side_ch_regs.sv
      - rtl/side_ch.sv
  - target: test
    files:
      - bench/side_ch_chk.sv
      - bench/side_ch_tb.sv

// File: bench/side_ch_chk.sv
// side channel checker: reference event and counter model with concurrent assertions on reads
module side_ch_chk
#(
	parameter int COUNTER_WIDTH = 16
)
(
	input logic clk,
	input logic rst_n,
	input side_ch_evt_pkg::rx_status_t rx,
	input side_ch_evt_pkg::tx_status_t tx,
	input side_ch_reg_pkg::reg_req_t req,
	input logic [side_ch_reg_pkg::REG_DATA_WIDTH-1:0] rd_data,
	input logic rd_valid,
	input logic [side_ch_evt_pkg::NUM_EVENTS-1:0] dut_events
);
	timeunit 1ns;
	timeprecision 1ps;

	import side_ch_evt_pkg::*;
	import side_ch_reg_pkg::*;

	int fail_count = 0;

	// shadow of the software configuration
	logic [47:0] ref_addr2;
	logic [10:0] ref_rssi_th;
	logic [NUM_EVENTS-1:0] ref_sel;

	logic data_frame;
	logic above_now;
	logic above_prev;
	logic [NUM_EVENTS-1:0] exp_next;
	logic [NUM_EVENTS-1:0] exp_events;
	logic [COUNTER_WIDTH-1:0] ref_cnt [NUM_EVENTS];
	logic [REG_DATA_WIDTH-1:0] exp_word;
	logic [REG_DATA_WIDTH-1:0] exp_rd_data;
	int cnt_idx;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ref_addr2 <= '0;
			ref_rssi_th <= '0;
			ref_sel <= '0;
		end
		else if (req.wr_en)
		begin
			if (req.addr == REG_ADDR2_LO)
				ref_addr2[31:0] <= req.wr_data;
			else if (req.addr == REG_ADDR2_HI)
				ref_addr2[47:32] <= req.wr_data[15:0];
			else if (req.addr == REG_RSSI_TH)
				ref_rssi_th <= req.wr_data[10:0];
			else if (req.addr == REG_EVENT_SEL)
			begin
				for (int i = 0; i < NUM_EVENTS; i++)
					ref_sel[i] <= req.wr_data[4*i];
			end
		end
	end

	// expected event sources, straight from the event table
	always_comb
	begin
		data_frame = (rx.fc_di[3:2] == FC_TYPE_DATA);
		above_now = ($signed(rx.rssi_half_db) > $signed(ref_rssi_th));
		exp_next[0] = ref_sel[0] ? rx.long_preamble_detected : rx.short_preamble_detected;
		exp_next[1] = rx.pkt_header_valid_strobe
			&& (ref_sel[1] ? !rx.pkt_header_valid : rx.pkt_header_valid);
		exp_next[2] = rx.fcs_in_strobe && (ref_sel[2] ? !rx.fcs_ok : rx.fcs_ok);
		if (ref_sel[3])
			exp_next[3] = rx.fcs_in_strobe && rx.pkt_for_me && data_frame;
		else
			exp_next[3] = rx.fcs_in_strobe && (rx.addr2 == ref_addr2);
		exp_next[4] = tx.phy_tx_start && (!ref_sel[4] || tx.tx_pkt_need_ack);
		exp_next[5] = ref_sel[5] ? (above_now && !above_prev) : tx.phy_tx_done;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			above_prev <= 1'b0;
			exp_events <= '0;
		end
		else
		begin
			above_prev <= above_now;
			exp_events <= exp_next;
		end
	end

	// model counters, a write to the counter word beats a same cycle event
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_EVENTS; i++)
		begin
			if (!rst_n)
				ref_cnt[i] <= '0;
			else if (req.wr_en && (int'(req.addr) == int'(REG_COUNTER_BASE) + i))
				ref_cnt[i] <= '0;
			else if (exp_events[i])
				ref_cnt[i] <= ref_cnt[i] + 1'b1;
		end
	end

	// expected word for the address on the bus
	always_comb
	begin
		exp_word = '0;
		cnt_idx = int'(req.addr) - int'(REG_COUNTER_BASE);
		if (req.addr == REG_ADDR2_LO)
			exp_word = ref_addr2[31:0];
		else if (req.addr == REG_ADDR2_HI)
			exp_word = {16'h0000, ref_addr2[47:32]};
		else if (req.addr == REG_RSSI_TH)
			exp_word = {{21{ref_rssi_th[10]}}, ref_rssi_th};
		else if (req.addr == REG_EVENT_SEL)
		begin
			for (int i = 0; i < NUM_EVENTS; i++)
				exp_word[4*i] = ref_sel[i];
		end
		else if (cnt_idx >= 0 && cnt_idx < NUM_EVENTS)
			exp_word = 32'(ref_cnt[cnt_idx]);
	end

	always_ff @(posedge clk)
	begin
		if (req.rd_en)
			exp_rd_data <= exp_word;
	end

	a_rd_valid_reset: assert property (@(posedge clk) !rst_n |=> !rd_valid)
		else
		begin
			fail_count++;
			$error("rd_valid was high at %0t right after a reset cycle", $time);
		end

	a_rd_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
		req.rd_en |=> rd_valid)
		else
		begin
			fail_count++;
			$error("rd_valid did not rise at %0t one cycle after rd_en", $time);
		end

	a_rd_valid_only: assert property (@(posedge clk) disable iff (!rst_n)
		!req.rd_en |=> !rd_valid)
		else
		begin
			fail_count++;
			$error("rd_valid was high at %0t without a read one cycle before", $time);
		end

	a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid |-> (rd_data == exp_rd_data))
		else
		begin
			fail_count++;
			$error("mismatch at %0t: rd_data %h, expected %h", $time,
				$sampled(rd_data), $sampled(exp_rd_data));
		end

	a_events: assert property (@(posedge clk) disable iff (!rst_n)
		dut_events == exp_events)
		else
		begin
			fail_count++;
			$error("mismatch at %0t: events %b, expected %b", $time,
				$sampled(dut_events), $sampled(exp_events));
		end

endmodule

bind side_ch side_ch_chk
#(
	.COUNTER_WIDTH(COUNTER_WIDTH)
)
side_ch_chk_inst
(
	.clk(clk),
	.rst_n(rst_n),
	.rx(rx),
	.tx(tx),
	.req(req),
	.rd_data(rd_data),
	.rd_valid(rd_valid),
	.dut_events(events)
);

// File: bench/side_ch_tb.sv
// side channel testbench: random status traffic, register accesses and final report
module side_ch_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import side_ch_evt_pkg::*;
	import side_ch_reg_pkg::*;

	localparam int COUNTER_WIDTH = 16;
	localparam int RESET_CYCLES = 5;
	localparam int PHASE_CYCLES = 400;
	// long enough to roll a 16 bit counter over
	localparam int WRAP_CYCLES = 65600;
	localparam int EXTRA_CYCLES = 600;
	localparam int PLANNED_CYCLES = RESET_CYCLES + 2 * PHASE_CYCLES + WRAP_CYCLES + EXTRA_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;
	localparam int RSSI_TH = -180;

	logic clk;
	logic rst_n;
	rx_status_t rx;
	tx_status_t tx;
	reg_req_t req;
	logic [REG_DATA_WIDTH-1:0] rd_data;
	logic rd_valid;

	logic [31:0] lfsr = 32'h9a92_dc84;
	logic [47:0] addr2_target;
	int rssi_off = 0;
	int cycle_count = 0;
	int timeout_count = 0;

	side_ch
	#(
		.COUNTER_WIDTH(COUNTER_WIDTH)
	)
	side_ch_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.rx(rx),
		.tx(tx),
		.req(req),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic reg_write(input logic [REG_ADDR_WIDTH-1:0] a, input logic [31:0] d);
		@(posedge clk);
		req <= '{wr_en: 1'b1, rd_en: 1'b0, addr: a, wr_data: d};
		@(posedge clk);
		req <= '0;
	endtask

	task automatic reg_read(input logic [REG_ADDR_WIDTH-1:0] a);
		@(posedge clk);
		req <= '{wr_en: 1'b0, rd_en: 1'b1, addr: a, wr_data: 32'h0};
		@(posedge clk);
		req <= '0;
	endtask

	task automatic read_all_words();
		for (int a = 0; a < 32; a++)
			reg_read(REG_ADDR_WIDTH'(a));
	endtask

	task automatic read_counters();
		for (int i = 0; i < NUM_EVENTS; i++)
			reg_read(REG_COUNTER_BASE + REG_ADDR_WIDTH'(i));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			rx <= '0;
			tx <= '0;
			req <= '0;
		end
	endtask

	// one cycle of random status, now and then a counter clear
	task automatic drive_random_cycle();
		rx_status_t r;
		tx_status_t t;
		reg_req_t q;
		int idx;
		r.short_preamble_detected = (take_bits(2) == 0);
		r.long_preamble_detected = (take_bits(2) == 0);
		r.pkt_header_valid = 1'(take_bits(1));
		r.pkt_header_valid_strobe = (take_bits(2) == 0);
		r.fcs_in_strobe = (take_bits(2) == 0);
		r.fcs_ok = 1'(take_bits(1));
		r.pkt_for_me = 1'(take_bits(1));
		r.fc_di = 16'(take_bits(16));
		if (take_bits(2) != 0)
			r.addr2 = addr2_target;
		else
		begin
			r.addr2[47:32] = 16'(take_bits(16));
			r.addr2[31:0] = take_bits(32);
		end
		// random walk around the threshold
		if (take_bits(1))
			rssi_off = (rssi_off < 6) ? rssi_off + 1 : rssi_off;
		else
			rssi_off = (rssi_off > -6) ? rssi_off - 1 : rssi_off;
		r.rssi_half_db = 11'(RSSI_TH + rssi_off);
		t.phy_tx_start = (take_bits(2) == 0);
		t.phy_tx_done = (take_bits(2) == 0);
		t.tx_pkt_need_ack = 1'(take_bits(1));
		q = '0;
		if (take_bits(5) == 0)
		begin
			idx = int'(take_bits(3)) % NUM_EVENTS;
			q.wr_en = 1'b1;
			q.addr = REG_COUNTER_BASE + REG_ADDR_WIDTH'(idx);
			q.wr_data = take_bits(32);
		end
		@(posedge clk);
		rx <= r;
		tx <= t;
		req <= q;
	endtask

	task automatic run_phase(input logic [31:0] sel_word);
		reg_write(REG_EVENT_SEL, sel_word);
		reg_read(REG_EVENT_SEL);
		repeat (PHASE_CYCLES)
			drive_random_cycle();
		idle_cycles(3);
		read_counters();
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			timeout_count = 1;
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d, timeouts: %0d",
				side_ch_inst.side_ch_chk_inst.fail_count, timeout_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		rx = '0;
		tx = '0;
		// a read strobe inside reset must not raise rd_valid
		req = '{wr_en: 1'b0, rd_en: 1'b1, addr: REG_ADDR2_LO, wr_data: 32'h0};
		addr2_target[31:0] = take_bits(32);
		addr2_target[47:32] = 16'(take_bits(16));
		repeat (RESET_CYCLES - 2) @(posedge clk);
		req <= '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// everything reads zero out of reset
		read_all_words();

		// upper bits carry junk to exercise masking
		reg_write(REG_ADDR2_LO, addr2_target[31:0]);
		reg_write(REG_ADDR2_HI, {16'h5c3a, addr2_target[47:32]});
		reg_write(REG_RSSI_TH, {21'h1a5a5, 11'(RSSI_TH)});
		reg_write(5'd12, 32'hffff_ffff);
		read_all_words();

		run_phase(32'heeee_eeee);
		run_phase(32'hcd11_1111);

		// event on counter 4 lands in the cycle of its clear
		@(posedge clk);
		tx <= '{phy_tx_start: 1'b1, phy_tx_done: 1'b0, tx_pkt_need_ack: 1'b1};
		@(posedge clk);
		tx <= '0;
		req <= '{wr_en: 1'b1, rd_en: 1'b0, addr: REG_COUNTER_BASE + 5'd4, wr_data: 32'h0};
		idle_cycles(3);
		read_counters();

		// long tx start burst to roll counter 4 over
		repeat (WRAP_CYCLES)
		begin
			@(posedge clk);
			tx <= '{phy_tx_start: 1'b1, phy_tx_done: 1'b0, tx_pkt_need_ack: 1'b1};
		end
		idle_cycles(3);
		read_counters();
		idle_cycles(2);

		$display("errors: %0d, timeouts: %0d",
			side_ch_inst.side_ch_chk_inst.fail_count, timeout_count);
		if (side_ch_inst.side_ch_chk_inst.fail_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: files.f
rtl/side_ch_evt_pkg.sv
rtl/side_ch_reg_pkg.sv
rtl/side_ch_event_sel.sv
rtl/side_ch_counter_bank.sv
rtl/side_ch_regs.sv
rtl/side_ch.sv
bench/side_ch_chk.sv
bench/side_ch_tb.sv

// File: rtl/side_ch.sv
// side channel statistics top: event selection, event counters and register port
module side_ch
#(
	parameter int COUNTER_WIDTH = 16
)
(
	input  logic clk,
	input  logic rst_n,
	input  side_ch_evt_pkg::rx_status_t rx,
	input  side_ch_evt_pkg::tx_status_t tx,
	input  side_ch_reg_pkg::reg_req_t req,
	output logic [side_ch_reg_pkg::REG_DATA_WIDTH-1:0] rd_data,
	output logic rd_valid
);
	import side_ch_evt_pkg::*;
	import side_ch_reg_pkg::*;

	logic [NUM_EVENTS-1:0] events;
	logic [NUM_EVENTS-1:0] clear;
	logic [NUM_EVENTS-1:0][COUNTER_WIDTH-1:0] counters;
	side_ch_cfg_t cfg;

	// status to registered event pulses
	side_ch_event_sel side_ch_event_sel_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.rx(rx),
		.tx(tx),
		.cfg(cfg),
		.events(events)
	);

	side_ch_counter_bank
	#(
		.COUNTER_WIDTH(COUNTER_WIDTH)
	)
	side_ch_counter_bank_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.events(events),
		.clear(clear),
		.counters(counters)
	);

	// software side, also the source of counter clears
	side_ch_regs
	#(
		.COUNTER_WIDTH(COUNTER_WIDTH)
	)
	side_ch_regs_inst
	(
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.counters(counters),
		.cfg(cfg),
		.clear(clear),
		.rd_data(rd_data),
		.rd_valid(rd_valid)
	);

endmodule

// File: rtl/side_ch_counter_bank.sv
// side channel counter bank: one wrapping counter per event channel, clearable by software
module side_ch_counter_bank
#(
	parameter int COUNTER_WIDTH = 16
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic [side_ch_evt_pkg::NUM_EVENTS-1:0] events,
	input  logic [side_ch_evt_pkg::NUM_EVENTS-1:0] clear,
	output logic [side_ch_evt_pkg::NUM_EVENTS-1:0][COUNTER_WIDTH-1:0] counters
);
	import side_ch_evt_pkg::*;

	// clear wins over a coincident event
	// counters roll over to zero past their maximum
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			counters <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_EVENTS; i++)
			begin
				if (clear[i])
					counters[i] <= '0;
				else if (events[i])
					counters[i] <= counters[i] + 1'b1;
			end
		end
	end

endmodule

// File: rtl/side_ch_event_sel.sv
// side channel event select: builds six registered event pulses from rx and tx status
module side_ch_event_sel
(
	input  logic clk,
	input  logic rst_n,
	input  side_ch_evt_pkg::rx_status_t rx,
	input  side_ch_evt_pkg::tx_status_t tx,
	input  side_ch_reg_pkg::side_ch_cfg_t cfg,
	output logic [side_ch_evt_pkg::NUM_EVENTS-1:0] events
);
	import side_ch_evt_pkg::*;

	logic is_data;
	logic addr2_match;
	logic rssi_above;
	logic rssi_above_d;
	logic rssi_rise;
	logic [NUM_EVENTS-1:0] src0;
	logic [NUM_EVENTS-1:0] src1;
	logic [NUM_EVENTS-1:0] events_next;

	// frame decode of the current packet
	assign is_data = (rx.fc_di[3:2] == FC_TYPE_DATA);
	assign addr2_match = (rx.addr2 == cfg.addr2_target);

	// signed compare against the software threshold
	assign rssi_above = ($signed(rx.rssi_half_db) > $signed(cfg.rssi_th));
	assign rssi_rise = rssi_above & ~rssi_above_d;

	// previous above-threshold state for edge detection
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rssi_above_d <= 1'b0;
		else
			rssi_above_d <= rssi_above;
	end

	// candidate sources for select 0
	always_comb
	begin
		src0[0] = rx.short_preamble_detected;
		src0[1] = rx.pkt_header_valid_strobe & rx.pkt_header_valid;
		src0[2] = rx.fcs_in_strobe & rx.fcs_ok;
		src0[3] = rx.fcs_in_strobe & addr2_match;
		src0[4] = tx.phy_tx_start;
		src0[5] = tx.phy_tx_done;
	end

	// candidate sources for select 1
	always_comb
	begin
		src1[0] = rx.long_preamble_detected;
		src1[1] = rx.pkt_header_valid_strobe & ~rx.pkt_header_valid;
		src1[2] = rx.fcs_in_strobe & ~rx.fcs_ok;
		src1[3] = rx.fcs_in_strobe & rx.pkt_for_me & is_data;
		src1[4] = tx.phy_tx_start & tx.tx_pkt_need_ack;
		src1[5] = rssi_rise;
	end

	// per channel pick by its select bit
	assign events_next = (src1 & cfg.event_sel) | (src0 & ~cfg.event_sel);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			events <= '0;
		else
			events <= events_next;
	end

endmodule

// File: rtl/side_ch_evt_pkg.sv
// side channel event package: baseband and MAC status types, event count and frame codes
package side_ch_evt_pkg;

	// number of selectable event channels and counters
	localparam int NUM_EVENTS = 6;

	// frame control type field, bits 3:2 of fc_di
	localparam logic [1:0] FC_TYPE_DATA = 2'd2;

	// receive side status from the baseband and the MAC
	typedef struct packed
	{
		logic short_preamble_detected;
		logic long_preamble_detected;
		// header decode result, qualified by its strobe
		logic pkt_header_valid;
		logic pkt_header_valid_strobe;
		// fcs check result, qualified by its strobe
		logic fcs_in_strobe;
		logic fcs_ok;
		logic pkt_for_me;
		logic [15:0] fc_di;
		logic [47:0] addr2;
		// received power in half dB steps
		logic signed [10:0] rssi_half_db;
	} rx_status_t;

	// transmit side status
	typedef struct packed
	{
		logic phy_tx_start;
		logic phy_tx_done;
		logic tx_pkt_need_ack;
	} tx_status_t;

endpackage

// File: rtl/side_ch_reg_pkg.sv
// side channel register package: register bus request, configuration and word addresses
package side_ch_reg_pkg;

	localparam int REG_ADDR_WIDTH = 5;
	localparam int REG_DATA_WIDTH = 32;

	// word addresses of the register map
	localparam logic [REG_ADDR_WIDTH-1:0] REG_ADDR2_LO = 5'd7;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_ADDR2_HI = 5'd8;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_RSSI_TH = 5'd9;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_EVENT_SEL = 5'd19;
	// counters occupy the last six words, 26 to 31
	localparam logic [REG_ADDR_WIDTH-1:0] REG_COUNTER_BASE = 5'd26;

	// one register access, wr_en and rd_en are single cycle strobes
	typedef struct packed
	{
		logic wr_en;
		logic rd_en;
		logic [REG_ADDR_WIDTH-1:0] addr;
		logic [REG_DATA_WIDTH-1:0] wr_data;
	} reg_req_t;

	// software configuration seen by the event logic
	typedef struct packed
	{
		logic [47:0] addr2_target;
		logic signed [10:0] rssi_th;
		// one select bit per event channel
		logic [side_ch_evt_pkg::NUM_EVENTS-1:0] event_sel;
	} side_ch_cfg_t;

endpackage

// File: rtl/side_ch_regs.sv
// side channel registers: configuration storage, counter clear decode and read data mux
module side_ch_regs
#(
	parameter int COUNTER_WIDTH = 16
)
(
	input  logic clk,
	input  logic rst_n,
	input  side_ch_reg_pkg::reg_req_t req,
	input  logic [side_ch_evt_pkg::NUM_EVENTS-1:0][COUNTER_WIDTH-1:0] counters,
	output side_ch_reg_pkg::side_ch_cfg_t cfg,
	output logic [side_ch_evt_pkg::NUM_EVENTS-1:0] clear,
	output logic [side_ch_reg_pkg::REG_DATA_WIDTH-1:0] rd_data,
	output logic rd_valid
);
	import side_ch_evt_pkg::*;
	import side_ch_reg_pkg::*;

	logic [REG_DATA_WIDTH-1:0] rd_mux;

	// configuration writes, unmapped addresses fall through
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			cfg <= '0;
		end
		else if (req.wr_en)
		begin
			case (req.addr)
				REG_ADDR2_LO: cfg.addr2_target[31:0] <= req.wr_data;
				REG_ADDR2_HI: cfg.addr2_target[47:32] <= req.wr_data[15:0];
				REG_RSSI_TH: cfg.rssi_th <= req.wr_data[10:0];
				REG_EVENT_SEL:
				begin
					// select bits sit on nibble boundaries
					for (int i = 0; i < NUM_EVENTS; i++)
						cfg.event_sel[i] <= req.wr_data[4*i];
				end
				default:
				begin
				end
			endcase
		end
	end

	// one-hot clear in the cycle of a counter write
	always_comb
	begin
		for (int i = 0; i < NUM_EVENTS; i++)
			clear[i] = req.wr_en && (req.addr == REG_COUNTER_BASE + i);
	end

	// read mux, unmapped words return zero
	always_comb
	begin
		rd_mux = '0;
		case (req.addr)
			REG_ADDR2_LO: rd_mux = cfg.addr2_target[31:0];
			REG_ADDR2_HI: rd_mux = REG_DATA_WIDTH'(cfg.addr2_target[47:32]);
			// signed cast extends the sign bit
			REG_RSSI_TH: rd_mux = REG_DATA_WIDTH'(cfg.rssi_th);
			REG_EVENT_SEL:
			begin
				for (int i = 0; i < NUM_EVENTS; i++)
					rd_mux[4*i] = cfg.event_sel[i];
			end
			default:
			begin
			end
		endcase
		// counters are zero extended
		for (int i = 0; i < NUM_EVENTS; i++)
		begin
			if (req.addr == REG_COUNTER_BASE + i)
				rd_mux = REG_DATA_WIDTH'(counters[i]);
		end
	end

	// read data is captured only on a read strobe
	always_ff @(posedge clk)
	begin
		if (req.rd_en)
			rd_data <= rd_mux;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= req.rd_en;
	end

endmodule
